// File: logic/rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// Data path and register width
`define XLEN 32

// Register index width and count
`define REG_AW 5
`define REG_NUM 32

// Byte address width
`define MEM_AW 32

// Memory data port, one byte per cycle
`define BYTE_W 8

`endif

// File: logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

   // Decoded instruction class
   typedef enum logic [2:0] {
      OP_NOP,
      OP_LUI,
      OP_IMM,
      OP_REG,
      OP_BRANCH,
      OP_JAL,
      OP_LOAD,
      OP_STORE
   } op_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   // Access width of a load or store
   typedef enum logic [1:0] {
      MEM_B,
      MEM_H,
      MEM_W
   } mem_size_e;

endpackage

`default_nettype wire

// File: logic/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_decoder
   import rv_exec_pkg::*;
(
   input  wire logic [`XLEN-1:0]   i_inst,
   output op_e                     o_op,
   output logic [`REG_AW-1:0]      o_rd,
   output logic [`REG_AW-1:0]      o_rs1,
   output logic [`REG_AW-1:0]      o_rs2,
   output logic [`XLEN-1:0]        o_imm,
   output alu_op_e                 o_alu_op,
   output logic [2:0]              o_funct3,
   output mem_size_e               o_mem_size,
   output logic                    o_mem_unsigned
);

   logic [6:0]       opcode;
   logic [6:0]       funct7;
   logic [`XLEN-1:0] imm_i;
   logic [`XLEN-1:0] imm_s;
   logic [`XLEN-1:0] imm_b;
   logic [`XLEN-1:0] imm_u;
   logic [`XLEN-1:0] imm_j;

   assign opcode   = i_inst[6:0];
   assign funct7   = i_inst[31:25];
   assign o_funct3 = i_inst[14:12];
   assign o_rd     = i_inst[11:7];
   assign o_rs1    = i_inst[19:15];
   assign o_rs2    = i_inst[24:20];

   // Sign-extended immediates per format
   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
   assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
   assign imm_u = {i_inst[31:12], 12'b0};
   assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

   assign o_mem_unsigned = o_funct3[2];

   always_comb begin
      case (o_funct3[1:0])
         2'b00:   o_mem_size = MEM_B;
         2'b01:   o_mem_size = MEM_H;
         default: o_mem_size = MEM_W;
      endcase
   end

   always_comb begin
      o_op     = OP_NOP;
      o_alu_op = ALU_ADD;
      o_imm    = imm_i;
      case (opcode)
         7'b0110111: begin
            o_op  = OP_LUI;
            o_imm = imm_u;
         end
         7'b0010011: begin
            // ADDI only
            if (o_funct3 == 3'b000) begin
               o_op = OP_IMM;
            end
         end
         7'b0110011: begin
            o_op = OP_REG;
            case ({funct7, o_funct3})
               {7'h00, 3'h0}: o_alu_op = ALU_ADD;
               {7'h20, 3'h0}: o_alu_op = ALU_SUB;
               {7'h00, 3'h1}: o_alu_op = ALU_SLL;
               {7'h00, 3'h2}: o_alu_op = ALU_SLT;
               {7'h00, 3'h3}: o_alu_op = ALU_SLTU;
               {7'h00, 3'h4}: o_alu_op = ALU_XOR;
               {7'h00, 3'h5}: o_alu_op = ALU_SRL;
               {7'h20, 3'h5}: o_alu_op = ALU_SRA;
               {7'h00, 3'h6}: o_alu_op = ALU_OR;
               {7'h00, 3'h7}: o_alu_op = ALU_AND;
               default:       o_op     = OP_NOP;
            endcase
         end
         7'b1100011: begin
            o_imm = imm_b;
            if (o_funct3[2:1] != 2'b01) begin
               o_op = OP_BRANCH;
            end
         end
         7'b1101111: begin
            o_op  = OP_JAL;
            o_imm = imm_j;
         end
         7'b0000011: begin
            if (o_funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
               o_op = OP_LOAD;
            end
         end
         7'b0100011: begin
            o_imm = imm_s;
            if (o_funct3 inside {3'b000, 3'b001, 3'b010}) begin
               o_op = OP_STORE;
            end
         end
         default: o_op = OP_NOP;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_regfile (
   input  wire logic              clk,
   input  wire logic              i_arst_n,
   input  wire logic [`REG_AW-1:0] i_rs1,
   input  wire logic [`REG_AW-1:0] i_rs2,
   input  wire logic [`REG_AW-1:0] i_rd,
   input  wire logic              i_we,
   input  wire logic [`XLEN-1:0]   i_wdata,
   output logic [`XLEN-1:0]        o_rs1_data,
   output logic [`XLEN-1:0]        o_rs2_data
);

   // x0 has no storage
   logic [`XLEN-1:0] regs [`REG_NUM-1:1];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 1; i < `REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_rd != '0) begin
         regs[i_rd] <= i_wdata;
      end
   end

   assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
   assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_alu
   import rv_exec_pkg::*;
(
   input  alu_op_e                i_op,
   input  wire logic [`XLEN-1:0]  i_a,
   input  wire logic [`XLEN-1:0]  i_b,
   output logic [`XLEN-1:0]       o_result
);

   logic [4:0] shamt;

   // Only the low five bits shift
   assign shamt = i_b[4:0];

   always_comb begin
      case (i_op)
         ALU_ADD:  o_result = i_a + i_b;
         ALU_SUB:  o_result = i_a - i_b;
         ALU_SLL:  o_result = i_a << shamt;
         ALU_SLT:  o_result = `XLEN'($signed(i_a) < $signed(i_b));
         ALU_SLTU: o_result = `XLEN'(i_a < i_b);
         ALU_XOR:  o_result = i_a ^ i_b;
         ALU_SRL:  o_result = i_a >> shamt;
         ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
         ALU_OR:   o_result = i_a | i_b;
         ALU_AND:  o_result = i_a & i_b;
         default:  o_result = i_a + i_b;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/rv_lsu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_lsu
   import rv_exec_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              i_arst_n,
   input  wire logic              i_start,
   input  wire logic              i_store,
   input  mem_size_e              i_size,
   input  wire logic              i_unsigned,
   input  wire logic [`MEM_AW-1:0] i_addr,
   input  wire logic [`XLEN-1:0]   i_wdata,
   output logic                   o_busy,
   output logic                   o_load_valid,
   output logic [`XLEN-1:0]        o_load_data,
   output logic [`MEM_AW-1:0]      o_mem_addr,
   output logic                   o_mem_we,
   output logic [`BYTE_W-1:0]      o_mem_wdata,
   input  wire logic [`BYTE_W-1:0] i_mem_rdata
);

   typedef enum logic {ST_IDLE, ST_XFER} state_e;

   state_e             state;
   logic [1:0]         cnt;
   logic               store_q;
   mem_size_e          size_q;
   logic               unsigned_q;
   logic [`MEM_AW-1:0] addr_q;
   logic [`XLEN-1:0]   shreg;
   logic [1:0]         last_q;
   logic [`XLEN-1:0]   assembled;

   // Index of the final byte for an access size
   function automatic logic [1:0] byte_last(input mem_size_e size);
      case (size)
         MEM_B:   return 2'd0;
         MEM_H:   return 2'd1;
         default: return 2'd3;
      endcase
   endfunction

   assign last_q = byte_last(size_q);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= ST_IDLE;
         cnt     <= '0;
         store_q <= 1'b0;
         size_q  <= MEM_W;
      end else if (state == ST_IDLE) begin
         if (i_start) begin
            state   <= ST_XFER;
            cnt     <= '0;
            store_q <= i_store;
            size_q  <= i_size;
         end
      end else begin
         cnt <= cnt + 2'd1;
         if (cnt == last_q) begin
            state <= ST_IDLE;
         end
      end
   end

   // Store bytes leave from the top, load bytes enter at the bottom
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && i_start) begin
         addr_q     <= i_addr;
         unsigned_q <= i_unsigned;
         shreg      <= i_store ? i_wdata << (8 * (3 - byte_last(i_size))) : '0;
      end else if (state == ST_XFER) begin
         shreg <= {shreg[`XLEN-`BYTE_W-1:0], i_mem_rdata};
      end
   end

   assign o_busy       = (state == ST_XFER);
   assign o_mem_addr   = addr_q + `MEM_AW'(cnt);
   assign o_mem_we     = o_busy && store_q;
   assign o_mem_wdata  = shreg[`XLEN-1:`XLEN-`BYTE_W];
   assign o_load_valid = o_busy && !store_q && (cnt == last_q);

   // Final byte is still on the read port
   assign assembled = {shreg[`XLEN-`BYTE_W-1:0], i_mem_rdata};

   always_comb begin
      case (size_q)
         MEM_B: o_load_data = unsigned_q ? {24'b0, assembled[7:0]}
                                         : {{24{assembled[7]}}, assembled[7:0]};
         MEM_H: o_load_data = unsigned_q ? {16'b0, assembled[15:0]}
                                         : {{16{assembled[15]}}, assembled[15:0]};
         default: o_load_data = assembled;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/rv_exec_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_ctrl
   import rv_exec_pkg::*;
(
   input  wire logic             clk,
   input  wire logic             i_arst_n,
   input  wire logic             i_inst_valid,
   input  wire logic [`XLEN-1:0] i_pc,
   input  op_e                   i_op,
   input  wire logic [2:0]       i_funct3,
   input  wire logic [`XLEN-1:0] i_imm,
   input  wire logic [`XLEN-1:0] i_rs1_data,
   input  wire logic [`XLEN-1:0] i_rs2_data,
   input  wire logic [`XLEN-1:0] i_alu_result,
   input  wire logic [`XLEN-1:0] i_load_data,
   input  wire logic             i_lsu_busy,
   input  wire logic             i_load_valid,
   output logic                  o_ready,
   output logic                  o_lsu_start,
   output logic                  o_rf_we,
   output logic [`XLEN-1:0]      o_rf_wdata,
   output logic                  o_alu_b_sel_imm,
   output logic                  o_pc_change,
   output logic [`XLEN-1:0]      o_new_pc
);

   logic accept;
   logic taken;

   assign o_ready     = !(i_lsu_busy || i_load_valid);
   assign accept      = i_inst_valid && o_ready;
   assign o_lsu_start = accept && (i_op inside {OP_LOAD, OP_STORE});

   // Address and ADDI both add the immediate
   assign o_alu_b_sel_imm = i_op inside {OP_IMM, OP_LOAD, OP_STORE};

   always_comb begin
      case (i_funct3)
         3'b000:  taken = (i_rs1_data == i_rs2_data);
         3'b001:  taken = (i_rs1_data != i_rs2_data);
         3'b100:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
         3'b101:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
         3'b110:  taken = (i_rs1_data < i_rs2_data);
         3'b111:  taken = (i_rs1_data >= i_rs2_data);
         default: taken = 1'b0;
      endcase
   end

   assign o_rf_we = i_load_valid || (accept && (i_op inside {OP_LUI, OP_IMM, OP_REG, OP_JAL}));

   always_comb begin
      if (i_load_valid) begin
         o_rf_wdata = i_load_data;
      end else begin
         case (i_op)
            OP_LUI:  o_rf_wdata = i_imm;
            OP_JAL:  o_rf_wdata = i_pc + `XLEN'(4);
            default: o_rf_wdata = i_alu_result;
         endcase
      end
   end

   // Jump request lasts one cycle
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_pc_change <= 1'b0;
      end else begin
         o_pc_change <= accept && (i_op == OP_JAL || (i_op == OP_BRANCH && taken));
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         o_new_pc <= i_pc + i_imm;
      end
   end

endmodule

`default_nettype wire

// File: logic/rv_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_top
   import rv_exec_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               i_arst_n,
   input  wire logic               i_inst_valid,
   input  wire logic [`XLEN-1:0]   i_inst,
   input  wire logic [`XLEN-1:0]   i_pc,
   output logic                    o_ready,
   output logic                    o_pc_change,
   output logic [`XLEN-1:0]        o_new_pc,
   output logic [`MEM_AW-1:0]      o_mem_addr,
   output logic                    o_mem_we,
   output logic [`BYTE_W-1:0]      o_mem_wdata,
   input  wire logic [`BYTE_W-1:0] i_mem_rdata
);

   op_e                dec_op;
   logic [`REG_AW-1:0] dec_rd;
   logic [`REG_AW-1:0] dec_rs1;
   logic [`REG_AW-1:0] dec_rs2;
   logic [`XLEN-1:0]   dec_imm;
   alu_op_e            dec_alu_op;
   logic [2:0]         dec_funct3;
   mem_size_e          dec_mem_size;
   logic               dec_mem_unsigned;
   logic [`XLEN-1:0]   rs1_data;
   logic [`XLEN-1:0]   rs2_data;
   logic [`XLEN-1:0]   alu_b;
   logic [`XLEN-1:0]   alu_result;
   logic               alu_b_sel_imm;
   logic               lsu_start;
   logic               lsu_busy;
   logic               load_valid;
   logic [`XLEN-1:0]   load_data;
   logic               rf_we;
   logic [`XLEN-1:0]   rf_wdata;

   // Operand B source
   assign alu_b = alu_b_sel_imm ? dec_imm : rs2_data;

   rv_decoder u_decoder (
      .i_inst         (i_inst),
      .o_op           (dec_op),
      .o_rd           (dec_rd),
      .o_rs1          (dec_rs1),
      .o_rs2          (dec_rs2),
      .o_imm          (dec_imm),
      .o_alu_op       (dec_alu_op),
      .o_funct3       (dec_funct3),
      .o_mem_size     (dec_mem_size),
      .o_mem_unsigned (dec_mem_unsigned)
   );

   rv_regfile u_regfile (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_rs1      (dec_rs1),
      .i_rs2      (dec_rs2),
      .i_rd       (dec_rd),
      .i_we       (rf_we),
      .i_wdata    (rf_wdata),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data)
   );

   rv_alu u_alu (
      .i_op     (dec_alu_op),
      .i_a      (rs1_data),
      .i_b      (alu_b),
      .o_result (alu_result)
   );

   // Opcode bit 5 separates STORE from LOAD
   rv_lsu u_lsu (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_start      (lsu_start),
      .i_store      (i_inst[5]),
      .i_size       (dec_mem_size),
      .i_unsigned   (dec_mem_unsigned),
      .i_addr       (alu_result),
      .i_wdata      (rs2_data),
      .o_busy       (lsu_busy),
      .o_load_valid (load_valid),
      .o_load_data  (load_data),
      .o_mem_addr   (o_mem_addr),
      .o_mem_we     (o_mem_we),
      .o_mem_wdata  (o_mem_wdata),
      .i_mem_rdata  (i_mem_rdata)
   );

   rv_exec_ctrl u_ctrl (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_inst_valid    (i_inst_valid),
      .i_pc            (i_pc),
      .i_op            (dec_op),
      .i_funct3        (dec_funct3),
      .i_imm           (dec_imm),
      .i_rs1_data      (rs1_data),
      .i_rs2_data      (rs2_data),
      .i_alu_result    (alu_result),
      .i_load_data     (load_data),
      .i_lsu_busy      (lsu_busy),
      .i_load_valid    (load_valid),
      .o_ready         (o_ready),
      .o_lsu_start     (lsu_start),
      .o_rf_we         (rf_we),
      .o_rf_wdata      (rf_wdata),
      .o_alu_b_sel_imm (alu_b_sel_imm),
      .o_pc_change     (o_pc_change),
      .o_new_pc        (o_new_pc)
   );

endmodule

`default_nettype wire

// File: tests/rv_exec_props.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_props (
   input wire logic        clk,
   input wire logic        i_arst_n,
   input wire logic        i_inst_valid,
   input wire logic [31:0] i_inst,
   input wire logic        o_ready,
   input wire logic        o_pc_change,
   input wire logic        o_mem_we
);

   logic is_load;
   logic is_store;
   logic mem_acc;
   int   fail_count = 0;

   assign is_load  = (i_inst[6:0] == 7'h03) &&
                     (i_inst[14:12] inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
   assign is_store = (i_inst[6:0] == 7'h23) && (i_inst[14:12] inside {3'd0, 3'd1, 3'd2});
   assign mem_acc  = i_inst_valid && o_ready && (is_load || is_store);

   a_we_not_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_mem_we |-> !o_ready)
      else begin
         fail_count++;
         $error("write while ready");
      end

   a_pc_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_pc_change |=> !o_pc_change)
      else begin
         fail_count++;
         $error("pc change held");
      end

   a_busy_byte: assert property (@(posedge clk) disable iff (!i_arst_n)
      mem_acc && i_inst[13:12] == 2'd0 |=> !o_ready ##1 o_ready)
      else begin
         fail_count++;
         $error("byte access ready timing");
      end

   a_busy_half: assert property (@(posedge clk) disable iff (!i_arst_n)
      mem_acc && i_inst[13:12] == 2'd1 |=> !o_ready [*2] ##1 o_ready)
      else begin
         fail_count++;
         $error("half access ready timing");
      end

   a_busy_word: assert property (@(posedge clk) disable iff (!i_arst_n)
      mem_acc && i_inst[13:12] == 2'd2 |=> !o_ready [*4] ##1 o_ready)
      else begin
         fail_count++;
         $error("word access ready timing");
      end

endmodule

bind rv_exec_top rv_exec_props u_rv_exec_props (.*);

`default_nettype wire

// File: tests/tb_rv_exec.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_cfg.svh"

module tb_rv_exec;

   // Instructions issued by the stimulus below
   localparam int NUM_INST = 138;

   logic               clk;
   logic               i_arst_n;
   logic               i_inst_valid;
   logic [`XLEN-1:0]   i_inst;
   logic [`XLEN-1:0]   i_pc;
   logic               o_ready;
   logic               o_pc_change;
   logic [`XLEN-1:0]   o_new_pc;
   logic [`MEM_AW-1:0] o_mem_addr;
   logic               o_mem_we;
   logic [`BYTE_W-1:0] o_mem_wdata;
   logic [`BYTE_W-1:0] i_mem_rdata;

   logic [7:0]         mem [0:1023];
   logic [31:0]        sh_reg [0:31];
   logic [31:0]        exp_addr_q[$];
   logic [7:0]         exp_byte_q[$];

   rv_exec_top u_rv_exec_top (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_inst_valid (i_inst_valid),
      .i_inst       (i_inst),
      .i_pc         (i_pc),
      .o_ready      (o_ready),
      .o_pc_change  (o_pc_change),
      .o_new_pc     (o_new_pc),
      .o_mem_addr   (o_mem_addr),
      .o_mem_we     (o_mem_we),
      .o_mem_wdata  (o_mem_wdata),
      .i_mem_rdata  (i_mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Byte memory, combinational read
   assign i_mem_rdata = mem[o_mem_addr[9:0]];

   always @(posedge clk) begin
      if (o_mem_we) begin
         mem[o_mem_addr[9:0]] <= o_mem_wdata;
      end
   end

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   // Every memory write is compared against the expected byte stream
   always @(negedge clk) begin
      if (o_mem_we) begin
         if (exp_addr_q.size() == 0) begin
            $display("Memory write at %h when no store was pending", o_mem_addr);
            $display("TESTBENCH FAILED");
            $fatal(1);
         end else begin
            check_val("store address", exp_addr_q.pop_front(), o_mem_addr);
            check_val("store data", {24'b0, exp_byte_q.pop_front()}, {24'b0, o_mem_wdata});
         end
      end
   end

   always @(posedge clk) begin
      if (u_rv_exec_top.u_rv_exec_props.fail_count != 0) begin
         $display("A bound assertion on the DUT failed");
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   end

   function automatic logic [31:0] rv_ref(input logic [31:0] inst, input logic [31:0] pc,
                                          output logic wr, output logic taken,
                                          output logic [31:0] target, output int nbytes,
                                          output logic [31:0] addr);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] v;
      logic [2:0]  f3;
      a      = sh_reg[inst[19:15]];
      b      = sh_reg[inst[24:20]];
      f3     = inst[14:12];
      imm_i  = {{20{inst[31]}}, inst[31:20]};
      imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      wr     = 1'b0;
      taken  = 1'b0;
      target = '0;
      nbytes = 0;
      addr   = '0;
      v      = '0;
      case (inst[6:0])
         7'h37: begin
            wr = 1'b1;
            v  = {inst[31:12], 12'b0};
         end
         7'h13: begin
            wr = 1'b1;
            v  = a + imm_i;
         end
         7'h33: begin
            wr = 1'b1;
            case (f3)
               3'd0: v = inst[30] ? a - b : a + b;
               3'd1: v = a << b[4:0];
               3'd2: v = {31'b0, $signed(a) < $signed(b)};
               3'd3: v = {31'b0, a < b};
               3'd4: v = a ^ b;
               3'd5: v = inst[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
               3'd6: v = a | b;
               default: v = a & b;
            endcase
         end
         7'h63: begin
            target = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            case (f3)
               3'd0: taken = (a == b);
               3'd1: taken = (a != b);
               3'd4: taken = ($signed(a) < $signed(b));
               3'd5: taken = ($signed(a) >= $signed(b));
               3'd6: taken = (a < b);
               default: taken = (a >= b);
            endcase
         end
         7'h6f: begin
            wr     = 1'b1;
            taken  = 1'b1;
            v      = pc + 32'd4;
            target = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         7'h03: begin
            wr     = 1'b1;
            addr   = a + imm_i;
            nbytes = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
            for (int k = 0; k < nbytes; k++) begin
               v = (v << 8) | mem[10'(addr + k)];
            end
            case (f3)
               3'd0: v = {{24{v[7]}}, v[7:0]};
               3'd1: v = {{16{v[15]}}, v[15:0]};
               3'd4: v = {24'b0, v[7:0]};
               3'd5: v = {16'b0, v[15:0]};
               default: v = v;
            endcase
         end
         7'h23: begin
            addr   = a + imm_s;
            nbytes = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
            v      = b;
         end
         default: v = '0;
      endcase
      return v;
   endfunction

   task automatic run_inst(input logic [31:0] inst, input logic [31:0] pc, input string name);
      logic        wr;
      logic        taken;
      logic [31:0] target;
      logic [31:0] addr;
      logic [31:0] val;
      int          nbytes;
      int          cycles;
      val = rv_ref(inst, pc, wr, taken, target, nbytes, addr);
      if (inst[6:0] == 7'h23) begin
         for (int k = 0; k < nbytes; k++) begin
            exp_addr_q.push_back(addr + k);
            exp_byte_q.push_back(8'(val >> (8 * (nbytes - 1 - k))));
         end
      end
      @(negedge clk);
      check_val({name, " ready at issue"}, 1, o_ready);
      i_inst       = inst;
      i_pc         = pc;
      i_inst_valid = 1'b1;
      @(negedge clk);
      // Instruction stays on the bus until a load writes back
      i_inst_valid = 1'b0;
      check_val({name, " pc change"}, taken, o_pc_change);
      if (taken) begin
         check_val({name, " new pc"}, target, o_new_pc);
      end
      cycles = 0;
      while (!o_ready) begin
         cycles++;
         if (cycles > 8) begin
            $display("o_ready stuck low after %s", name);
            $display("TESTBENCH FAILED");
            $fatal(1);
         end
         @(negedge clk);
      end
      check_val({name, " busy cycles"}, nbytes, cycles);
      check_val({name, " pending writes"}, 0, exp_addr_q.size());
      if (wr && inst[11:7] != 5'd0) begin
         sh_reg[inst[11:7]] = val;
      end
   endtask

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   task automatic load_const(input logic [4:0] rd, input logic [31:0] c);
      logic [19:0] upper;
      upper = c[31:12] + {19'b0, c[11]};
      run_inst({upper, rd, 7'h37}, 32'h0, "lui");
      run_inst(enc_i(c[11:0], rd, 3'd0, rd, 7'h13), 32'h0, "addi");
      check_val("constant build", c, sh_reg[rd]);
   endtask

   task automatic store_reg(input logic [4:0] rs, input logic [11:0] addr, input string name);
      run_inst(enc_s(addr, rs, 5'd0, 3'd2), 32'h0, name);
   endtask

   initial begin
      logic [2:0]  f3;
      logic [6:0]  f7;
      int          idx;
      logic [2:0]  br_f3 [0:5];
      logic [2:0]  ld_f3 [0:4];
      void'($urandom(32'hadb7));
      br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      ld_f3 = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};
      i_arst_n     = 1'b0;
      i_inst_valid = 1'b0;
      i_inst       = '0;
      i_pc         = '0;
      for (int a = 0; a < 1024; a++) begin
         mem[a] = 8'(a * 37) ^ 8'(a >> 3);
      end
      for (int r = 0; r < 32; r++) begin
         sh_reg[r] = '0;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      i_arst_n = 1'b1;

      // Constants and word stores
      for (int i = 0; i < 4; i++) begin
         load_const(5'd1, $urandom());
         store_reg(5'd1, 12'(12'h100 + 4 * i), "sw constant");
      end

      // Random register ops
      for (int r = 1; r <= 8; r++) begin
         load_const(5'(r), $urandom());
      end
      for (int i = 0; i < 40; i++) begin
         idx = $urandom_range(0, 9);
         f7  = (idx == 1 || idx == 7) ? 7'h20 : 7'h00;
         case (idx)
            0, 1: f3 = 3'd0;
            2: f3 = 3'd1;
            3: f3 = 3'd2;
            4: f3 = 3'd3;
            5: f3 = 3'd4;
            6, 7: f3 = 3'd5;
            8: f3 = 3'd6;
            default: f3 = 3'd7;
         endcase
         run_inst({f7, 5'($urandom_range(1, 15)), 5'($urandom_range(1, 15)), f3,
                   5'($urandom_range(1, 15)), 7'h33}, 32'h0, "reg op");
      end
      for (int r = 1; r <= 15; r++) begin
         store_reg(5'(r), 12'(12'h200 + 4 * r), "sw reg op");
      end
      load_const(5'd20, 32'h8000_0000);
      load_const(5'd21, 32'h7fff_ffff);
      run_inst({7'h00, 5'd21, 5'd20, 3'd2, 5'd22, 7'h33}, 32'h0, "slt boundary");
      run_inst({7'h00, 5'd21, 5'd20, 3'd3, 5'd23, 7'h33}, 32'h0, "sltu boundary");
      run_inst({7'h00, 5'd20, 5'd21, 3'd2, 5'd24, 7'h33}, 32'h0, "slt reversed");
      run_inst({7'h00, 5'd20, 5'd21, 3'd3, 5'd25, 7'h33}, 32'h0, "sltu reversed");
      for (int r = 22; r <= 25; r++) begin
         store_reg(5'(r), 12'(12'h280 + 4 * r), "sw slt");
      end

      // Branches over equal, unequal and boundary pairs
      for (int b = 0; b < 6; b++) begin
         run_inst(enc_b(13'h1ff0, 5'd21, 5'd20, br_f3[b]), 32'h1000, "branch min max");
         run_inst(enc_b(13'h0018, 5'd20, 5'd21, br_f3[b]), 32'h1000, "branch max min");
         run_inst(enc_b(13'h0040, 5'd20, 5'd20, br_f3[b]), 32'h1400, "branch equal");
         run_inst(enc_b(13'h1f00, 5'd2, 5'd1, br_f3[b]), 32'h1800, "branch random");
      end

      // JAL both directions
      run_inst(enc_j(21'h1ff800, 5'd5), 32'h2000, "jal back");
      run_inst(enc_j(21'h000100, 5'd6), 32'h3000, "jal fwd");
      store_reg(5'd5, 12'h2f0, "sw link back");
      store_reg(5'd6, 12'h2f4, "sw link fwd");

      // Loads from the fill pattern
      for (int i = 0; i < 5; i++) begin
         run_inst(enc_i(12'(12'h300 + 5 * i), 5'd0, ld_f3[i], 5'd7, 7'h03), 32'h0, "load");
         store_reg(5'd7, 12'(12'h380 + 4 * i), "sw load");
      end

      // Narrow stores and x0
      run_inst(enc_s(12'h3c0, 5'd1, 5'd0, 3'd0), 32'h0, "sb");
      run_inst(enc_s(12'h3c4, 5'd1, 5'd0, 3'd1), 32'h0, "sh");
      run_inst(enc_i(12'h07b, 5'd0, 3'd0, 5'd0, 7'h13), 32'h0, "addi x0");
      run_inst({20'hfffff, 5'd0, 7'h37}, 32'h0, "lui x0");
      store_reg(5'd0, 12'h3c8, "sw x0");

      // Last access still has its ready check pending
      repeat (2) @(negedge clk);

      if (exp_addr_q.size() != 0) begin
         $display("Expected memory writes never happened");
         $display("TESTBENCH FAILED");
         $fatal(1);
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

   // Upper bound of eight cycles per instruction
   initial begin
      #((10 + NUM_INST * 8) * 20);
      $display("Simulation timed out before all instructions finished");
      $display("TESTBENCH FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/rv_exec_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_lsu.sv
logic/rv_exec_ctrl.sv
logic/rv_exec_top.sv
tests/rv_exec_props.sv
tests/tb_rv_exec.sv
